/* source/gbPackage.sv */
package gbPackage;

	////////////////////////////////////////
	// Register bus
	////////////////////////////////////////

	// I/O register addressed by the current CPU access
	typedef enum logic [3:0] {
		RegNone,
		RegJoypad,
		RegDiv,
		RegTima,
		RegTma,
		RegTac,
		RegIf,
		RegIe
	} RegisterId;

	////////////////////////////////////////
	// Memory map
	////////////////////////////////////////

	// Work RAM window, smaller RAM sizes mirror inside it
	localparam logic [15:0] WorkRamBase = 16'hC000;
	localparam logic [15:0] WorkRamSpan = 16'h2000;

	// High RAM runs up to but not including IE
	localparam logic [15:0] HighRamBase = 16'hFF80;

	localparam logic [15:0] JoypadAddr = 16'hFF00;
	localparam logic [15:0] DivAddr = 16'hFF04;
	localparam logic [15:0] TimaAddr = 16'hFF05;
	localparam logic [15:0] TmaAddr = 16'hFF06;
	localparam logic [15:0] TacAddr = 16'hFF07;
	localparam logic [15:0] IfAddr = 16'hFF0F;
	localparam logic [15:0] IeAddr = 16'hFFFF;

	// Returned for any address nothing answers to
	localparam logic [7:0] UnmappedData = 8'hFF;

	////////////////////////////////////////
	// Interrupt sources
	////////////////////////////////////////

	localparam int IntTimer = 2;
	localparam int IntJoypad = 4;

endpackage

/* source/memoryUnit.sv */
`timescale 1ns/1ps

module memoryUnit #(
	parameter int WorkRamBytes = 256
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [15:0]          cpuAddr,
	input  logic [7:0]           cpuWriteData,
	input  logic                 cpuWe,
	input  logic                 cpuReadRequest,
	output logic [7:0]           cpuReadData,
	output gbPackage::RegisterId regSelect,
	output logic [7:0]           regWriteData,
	output logic                 timerWe,
	output logic                 interruptWe,
	output logic                 joypadWe,
	input  logic [7:0]           joypadData,
	input  logic [7:0]           divData,
	input  logic [7:0]           timaData,
	input  logic [7:0]           tmaData,
	input  logic [7:0]           tacData,
	input  logic [7:0]           ifData,
	input  logic [7:0]           ieData
);

	localparam int RamAddrWidth = $clog2(WorkRamBytes);

	logic [7:0] workRam [WorkRamBytes];
	logic [7:0] highRam [127];

	logic isWorkRam;
	logic isHighRam;
	logic [RamAddrWidth-1:0] workRamIndex;
	logic [6:0] highRamIndex;
	logic [7:0] readValue;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	assign isWorkRam = (cpuAddr >= gbPackage::WorkRamBase) &&
		(cpuAddr < gbPackage::WorkRamBase + gbPackage::WorkRamSpan);
	assign isHighRam = (cpuAddr >= gbPackage::HighRamBase) && (cpuAddr != gbPackage::IeAddr);

	// Low address bits only, so the RAM repeats across the window
	assign workRamIndex = cpuAddr[RamAddrWidth-1:0];
	assign highRamIndex = cpuAddr[6:0];

	always_comb begin
		case (cpuAddr)
			gbPackage::JoypadAddr: regSelect = gbPackage::RegJoypad;
			gbPackage::DivAddr:    regSelect = gbPackage::RegDiv;
			gbPackage::TimaAddr:   regSelect = gbPackage::RegTima;
			gbPackage::TmaAddr:    regSelect = gbPackage::RegTma;
			gbPackage::TacAddr:    regSelect = gbPackage::RegTac;
			gbPackage::IfAddr:     regSelect = gbPackage::RegIf;
			gbPackage::IeAddr:     regSelect = gbPackage::RegIe;
			default:               regSelect = gbPackage::RegNone;
		endcase
	end

	assign regWriteData = cpuWriteData;

	// One strobe per peripheral, only during the write cycle
	always_comb begin
		timerWe = 1'b0;
		interruptWe = 1'b0;
		joypadWe = 1'b0;
		if (cpuWe) begin
			case (regSelect)
				gbPackage::RegJoypad: joypadWe = 1'b1;
				gbPackage::RegDiv, gbPackage::RegTima,
				gbPackage::RegTma, gbPackage::RegTac: timerWe = 1'b1;
				gbPackage::RegIf, gbPackage::RegIe: interruptWe = 1'b1;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// RAM and read path
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (cpuWe && isWorkRam)
			workRam[workRamIndex] <= cpuWriteData;
		if (cpuWe && isHighRam)
			highRam[highRamIndex] <= cpuWriteData;
	end

	always_comb begin
		if (isWorkRam)
			readValue = workRam[workRamIndex];
		else if (isHighRam)
			readValue = highRam[highRamIndex];
		else begin
			case (regSelect)
				gbPackage::RegJoypad: readValue = joypadData | 8'hC0;  // P1 bits 7:6 unused
				gbPackage::RegDiv:    readValue = divData;
				gbPackage::RegTima:   readValue = timaData;
				gbPackage::RegTma:    readValue = tmaData;
				gbPackage::RegTac:    readValue = tacData | 8'hF8;
				gbPackage::RegIf:     readValue = ifData;
				gbPackage::RegIe:     readValue = ieData;
				default:              readValue = gbPackage::UnmappedData;
			endcase
		end
	end

	// Holds the last read until the next request
	always_ff @(posedge clock) begin
		if (reset)
			cpuReadData <= 8'h00;
		else if (cpuReadRequest)
			cpuReadData <= readValue;
	end

	strobesExclusive: assert property (@(posedge clock) disable iff (reset)
		!(cpuWe && cpuReadRequest));

endmodule

/* source/interruptController.sv */
`timescale 1ns/1ps

module interruptController (
	input  logic                 clock,
	input  logic                 reset,
	input  gbPackage::RegisterId regSelect,
	input  logic [7:0]           regWriteData,
	input  logic                 interruptWe,
	input  logic [4:0]           requests,
	output logic [7:0]           ifData,
	output logic [7:0]           ieData,
	output logic [4:0]           interruptPending
);

	// Sources present in this system
	localparam logic [4:0] SourceMask =
		5'((1 << gbPackage::IntTimer) | (1 << gbPackage::IntJoypad));

	logic [4:0] flags;
	logic [7:0] enables;
	logic [4:0] acceptedRequests;

	assign acceptedRequests = requests & SourceMask;

	////////////////////////////////////////
	// Flag and enable registers
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			flags <= 5'd0;
			enables <= 8'h00;
		end else begin
			// A request in the same cycle as an IF write keeps its bit set
			if (interruptWe && regSelect == gbPackage::RegIf)
				flags <= regWriteData[4:0] | acceptedRequests;
			else
				flags <= flags | acceptedRequests;

			if (interruptWe && regSelect == gbPackage::RegIe)
				enables <= regWriteData;
		end
	end

	assign ifData = {3'b111, flags};
	assign ieData = enables;
	assign interruptPending = enables[4:0] & flags;

	pendingOnlyEnabled: assert property (@(posedge clock) disable iff (reset)
		(interruptPending & ~ieData[4:0]) == 5'd0);

endmodule

/* source/timerUnit.sv */
`timescale 1ns/1ps

module timerUnit #(
	parameter int DividerWidth = 16
) (
	input  logic                 clock,
	input  logic                 reset,
	input  gbPackage::RegisterId regSelect,
	input  logic [7:0]           regWriteData,
	input  logic                 timerWe,
	output logic [7:0]           divData,
	output logic [7:0]           timaData,
	output logic [7:0]           tmaData,
	output logic [7:0]           tacData,
	output logic                 timerRequest
);

	logic [DividerWidth-1:0] divider;
	logic [7:0] tima;
	logic [7:0] tma;
	logic [2:0] tac;
	logic tapNow;
	logic tapPrev;
	logic timaTick;
	logic timaWrite;

	////////////////////////////////////////
	// Rate tap and edge detect
	////////////////////////////////////////

	always_comb begin
		case (tac[1:0])
			2'd0: tapNow = divider[9];
			2'd1: tapNow = divider[3];
			2'd2: tapNow = divider[5];
			default: tapNow = divider[7];
		endcase
	end

	// Falling edge of the tap, also caused by a DIV clear or a rate change
	assign timaTick = tac[2] && tapPrev && !tapNow;
	assign timaWrite = timerWe && (regSelect == gbPackage::RegTima);

	// CPU write to TIMA cancels the overflow
	assign timerRequest = timaTick && !timaWrite && (tima == 8'hFF);

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			divider <= '0;
			tapPrev <= 1'b0;
			tima <= 8'h00;
			tma <= 8'h00;
			tac <= 3'd0;
		end else begin
			tapPrev <= tapNow;

			if (timerWe && regSelect == gbPackage::RegDiv)
				divider <= '0;
			else
				divider <= divider + 1'b1;

			if (timaWrite)
				tima <= regWriteData;
			else if (timerRequest)
				tima <= tma;
			else if (timaTick)
				tima <= tima + 8'd1;

			if (timerWe && regSelect == gbPackage::RegTma)
				tma <= regWriteData;
			if (timerWe && regSelect == gbPackage::RegTac)
				tac <= regWriteData[2:0];
		end
	end

	assign divData = divider[DividerWidth-1 -: 8];
	assign timaData = tima;
	assign tmaData = tma;
	assign tacData = {5'b00000, tac};

	singleCycleRequest: assert property (@(posedge clock) disable iff (reset)
		timerRequest |=> !timerRequest);

endmodule

/* source/buttonPort.sv */
`timescale 1ns/1ps

module buttonPort (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [7:0]           buttons,
	input  gbPackage::RegisterId regSelect,
	input  logic [7:0]           regWriteData,
	input  logic                 joypadWe,
	output logic [7:0]           joypadData,
	output logic                 joypadRequest
);

	logic [7:0] buttonsMeta;
	logic [7:0] buttonsSync;
	logic [1:0] groupSelect;
	logic [3:0] pressed;
	logic [3:0] lines;
	logic [3:0] linesPrev;

	always_ff @(posedge clock) begin
		if (reset) begin
			buttonsMeta <= 8'h00;
			buttonsSync <= 8'h00;
			groupSelect <= 2'b11;
			linesPrev <= 4'hF;
		end else begin
			buttonsMeta <= buttons;
			buttonsSync <= buttonsMeta;
			linesPrev <= lines;
			if (joypadWe && regSelect == gbPackage::RegJoypad)
				groupSelect <= regWriteData[5:4];
		end
	end

	// Select bits are active low, both low merges the two groups
	always_comb begin
		pressed = 4'b0000;
		if (!groupSelect[0])
			pressed = pressed | buttonsSync[3:0];
		if (!groupSelect[1])
			pressed = pressed | buttonsSync[7:4];
	end

	assign lines = ~pressed;
	assign joypadData = {2'b00, groupSelect, lines};

	// Any selected line going low
	assign joypadRequest = |(linesPrev & ~lines);

endmodule

/* source/gbCore.sv */
`timescale 1ns/1ps

module gbCore #(
	parameter int WorkRamBytes = 256,
	parameter int DividerWidth = 16
) (
	input  logic        clock,
	input  logic        reset,
	input  logic [15:0] cpuAddr,
	input  logic [7:0]  cpuWriteData,
	input  logic        cpuWe,
	input  logic        cpuReadRequest,
	input  logic [7:0]  buttons,
	output logic [7:0]  cpuReadData,
	output logic [4:0]  interruptPending
);

	gbPackage::RegisterId regSelect;
	logic [7:0] regWriteData;
	logic timerWe;
	logic interruptWe;
	logic joypadWe;

	logic [7:0] joypadData;
	logic [7:0] divData;
	logic [7:0] timaData;
	logic [7:0] tmaData;
	logic [7:0] tacData;
	logic [7:0] ifData;
	logic [7:0] ieData;

	logic timerRequest;
	logic joypadRequest;
	logic [4:0] requests;

	////////////////////////////////////////
	// Interrupt request routing
	////////////////////////////////////////

	always_comb begin
		requests = 5'd0;
		requests[gbPackage::IntTimer] = timerRequest;
		requests[gbPackage::IntJoypad] = joypadRequest;
	end

	memoryUnit #(
		.WorkRamBytes(WorkRamBytes)
	) u_memoryUnit (
		.clock(clock),
		.reset(reset),
		.cpuAddr(cpuAddr),
		.cpuWriteData(cpuWriteData),
		.cpuWe(cpuWe),
		.cpuReadRequest(cpuReadRequest),
		.cpuReadData(cpuReadData),
		.regSelect(regSelect),
		.regWriteData(regWriteData),
		.timerWe(timerWe),
		.interruptWe(interruptWe),
		.joypadWe(joypadWe),
		.joypadData(joypadData),
		.divData(divData),
		.timaData(timaData),
		.tmaData(tmaData),
		.tacData(tacData),
		.ifData(ifData),
		.ieData(ieData)
	);

	interruptController u_interruptController (
		.clock(clock),
		.reset(reset),
		.regSelect(regSelect),
		.regWriteData(regWriteData),
		.interruptWe(interruptWe),
		.requests(requests),
		.ifData(ifData),
		.ieData(ieData),
		.interruptPending(interruptPending)
	);

	timerUnit #(
		.DividerWidth(DividerWidth)
	) u_timerUnit (
		.clock(clock),
		.reset(reset),
		.regSelect(regSelect),
		.regWriteData(regWriteData),
		.timerWe(timerWe),
		.divData(divData),
		.timaData(timaData),
		.tmaData(tmaData),
		.tacData(tacData),
		.timerRequest(timerRequest)
	);

	buttonPort u_buttonPort (
		.clock(clock),
		.reset(reset),
		.buttons(buttons),
		.regSelect(regSelect),
		.regWriteData(regWriteData),
		.joypadWe(joypadWe),
		.joypadData(joypadData),
		.joypadRequest(joypadRequest)
	);

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
	parameter int ResetCycles = 3
) (
	output logic clock,
	output logic reset
);

	// 10 ns period
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Released just after an edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (ResetCycles) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

/* tests/gbCoreChecker.sv */
`timescale 1ns/1ps

module gbCoreChecker #(
	parameter int WorkRamBytes = 256,
	parameter int DividerWidth = 16
) (
	input  logic        clock,
	input  logic        reset,
	input  logic [2:0]  phase,
	input  logic [15:0] cpuAddr,
	input  logic [7:0]  cpuWriteData,
	input  logic        cpuWe,
	input  logic        cpuReadRequest,
	input  logic [7:0]  buttons,
	input  logic [7:0]  cpuReadData,
	input  logic [4:0]  interruptPending,
	output int          errorCount,
	output int          readCount
);

	// Model state
	logic [7:0] workRam [WorkRamBytes];
	logic [7:0] highRam [127];
	logic [DividerWidth-1:0] divider;
	logic [7:0] tima;
	logic [7:0] tma;
	logic [2:0] tac;
	logic tapPrev;
	logic [4:0] flags;
	logic [7:0] enables;
	logic [1:0] select;
	logic [7:0] syncFirst;
	logic [7:0] syncSecond;
	logic [3:0] linesPrev;

	// Pending read check
	logic [7:0] expectedRead;
	logic [15:0] readAddr;
	logic [2:0] readPhase;
	logic readDue;

	function automatic string testName(input logic [2:0] p);
		case (p)
			3'd1: return "ram";
			3'd2: return "timer";
			3'd3: return "overflow";
			3'd4: return "joypad";
			3'd5: return "masking";
			default: return "reset";
		endcase
	endfunction

	// TAC rate to divider bit
	function automatic int tapPosition(input logic [1:0] rate);
		case (rate)
			2'd0: return 9;
			2'd1: return 3;
			2'd2: return 5;
			default: return 7;
		endcase
	endfunction

	task automatic reportMismatch(input string name, input string what,
		input logic [7:0] expected, input logic [7:0] actual);
		errorCount++;
		$display("[ERROR] %s: %s expected %02h actual %02h at %0t",
			name, what, expected, actual, $time);
	endtask

	////////////////////////////////////////
	// Model update at each rising edge
	////////////////////////////////////////

	always @(posedge clock) begin : modelStep
		logic inWorkRam;
		logic inHighRam;
		int ramIndex;
		int highIndex;
		logic [3:0] pressed;
		logic [3:0] lines;
		logic tapNow;
		logic tick;
		logic timaWrite;
		logic overflow;
		logic [4:0] raised;
		logic [7:0] readValue;

		if (reset) begin
			divider = '0;
			tapPrev = 1'b0;
			tima = 8'h00;
			tma = 8'h00;
			tac = 3'd0;
			flags = 5'd0;
			enables = 8'h00;
			select = 2'b11;
			syncFirst = 8'h00;
			syncSecond = 8'h00;
			linesPrev = 4'hF;
			expectedRead = 8'h00;
			readDue = 1'b0;
		end else begin
			inWorkRam = cpuAddr >= gbPackage::WorkRamBase &&
				cpuAddr < gbPackage::WorkRamBase + gbPackage::WorkRamSpan;
			inHighRam = cpuAddr >= gbPackage::HighRamBase && cpuAddr != gbPackage::IeAddr;
			ramIndex = (int'(cpuAddr) - int'(gbPackage::WorkRamBase)) % WorkRamBytes;
			highIndex = int'(cpuAddr) - int'(gbPackage::HighRamBase);

			// Selected groups, pressed keys pull the line low
			pressed = 4'h0;
			if (!select[0])
				pressed = pressed | syncSecond[3:0];
			if (!select[1])
				pressed = pressed | syncSecond[7:4];
			lines = ~pressed;

			tapNow = divider[tapPosition(tac[1:0])];
			tick = tac[2] && tapPrev && !tapNow;
			timaWrite = cpuWe && cpuAddr == gbPackage::TimaAddr;
			overflow = tick && !timaWrite && tima == 8'hFF;

			raised = 5'd0;
			raised[gbPackage::IntTimer] = overflow;
			raised[gbPackage::IntJoypad] = |(linesPrev & ~lines);

			if (inWorkRam)
				readValue = workRam[ramIndex];
			else if (inHighRam)
				readValue = highRam[highIndex];
			else begin
				case (cpuAddr)
					gbPackage::JoypadAddr: readValue = {2'b11, select, lines};
					gbPackage::DivAddr:    readValue = 8'(divider >> (DividerWidth - 8));
					gbPackage::TimaAddr:   readValue = tima;
					gbPackage::TmaAddr:    readValue = tma;
					gbPackage::TacAddr:    readValue = {5'b11111, tac};
					gbPackage::IfAddr:     readValue = {3'b111, flags};
					gbPackage::IeAddr:     readValue = enables;
					default:               readValue = gbPackage::UnmappedData;
				endcase
			end

			readDue = cpuReadRequest;
			if (cpuReadRequest) begin
				expectedRead = readValue;
				readAddr = cpuAddr;
				readPhase = phase;
			end

			// Reload uses TMA from before this edge
			if (timaWrite)
				tima = cpuWriteData;
			else if (overflow)
				tima = tma;
			else if (tick)
				tima = tima + 8'd1;

			if (cpuWe && cpuAddr == gbPackage::IfAddr)
				flags = cpuWriteData[4:0] | raised;
			else
				flags = flags | raised;

			if (cpuWe && cpuAddr == gbPackage::DivAddr)
				divider = '0;
			else
				divider = divider + 1;

			tapPrev = tapNow;
			syncSecond = syncFirst;
			syncFirst = buttons;
			linesPrev = lines;

			if (cpuWe) begin
				if (inWorkRam)
					workRam[ramIndex] = cpuWriteData;
				else if (inHighRam)
					highRam[highIndex] = cpuWriteData;
				case (cpuAddr)
					gbPackage::JoypadAddr: select = cpuWriteData[5:4];
					gbPackage::TmaAddr:    tma = cpuWriteData;
					gbPackage::TacAddr:    tac = cpuWriteData[2:0];
					gbPackage::IeAddr:     enables = cpuWriteData;
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Comparisons at the falling edge
	////////////////////////////////////////

	always @(negedge clock) begin : compareStep
		logic [4:0] expectedPending;

		if (reset) begin
			errorCount = 0;
			readCount = 0;
		end else begin
			expectedPending = enables[4:0] & flags;
			if (readDue) begin
				readCount++;
				if (cpuReadData !== expectedRead)
					reportMismatch(testName(readPhase), $sformatf("read of %04h", readAddr),
						expectedRead, cpuReadData);
			end
			if (interruptPending !== expectedPending)
				reportMismatch(testName(phase), "interruptPending",
					{3'b000, expectedPending}, {3'b000, interruptPending});
		end
	end

endmodule

/* tests/gbCoreTb.sv */
`timescale 1ns/1ps

module gbCoreTb;

	localparam int WorkRamBytes = 256;
	localparam int DividerWidth = 16;

	// Cycle budget of each test phase
	localparam int RamBudget = 1200;
	localparam int TimerBudget = 14000;
	localparam int OverflowBudget = 2500;
	localparam int JoypadBudget = 1500;
	localparam int MaskBudget = 1200;
	localparam int CycleLimit =
		2 * (RamBudget + TimerBudget + OverflowBudget + JoypadBudget + MaskBudget);

	logic clock;
	logic reset;
	logic [15:0] cpuAddr;
	logic [7:0] cpuWriteData;
	logic cpuWe;
	logic cpuReadRequest;
	logic [7:0] buttons;
	logic [7:0] cpuReadData;
	logic [4:0] interruptPending;
	logic [2:0] phase;

	int seed;
	int cycles = 0;
	int waitFailures;
	int errorCount;
	int readCount;

	clockGen clockSource (
		.clock(clock),
		.reset(reset)
	);

	gbCore #(
		.WorkRamBytes(WorkRamBytes),
		.DividerWidth(DividerWidth)
	) u_gbCore (
		.clock(clock),
		.reset(reset),
		.cpuAddr(cpuAddr),
		.cpuWriteData(cpuWriteData),
		.cpuWe(cpuWe),
		.cpuReadRequest(cpuReadRequest),
		.buttons(buttons),
		.cpuReadData(cpuReadData),
		.interruptPending(interruptPending)
	);

	gbCoreChecker #(
		.WorkRamBytes(WorkRamBytes),
		.DividerWidth(DividerWidth)
	) responseCheck (
		.clock(clock),
		.reset(reset),
		.phase(phase),
		.cpuAddr(cpuAddr),
		.cpuWriteData(cpuWriteData),
		.cpuWe(cpuWe),
		.cpuReadRequest(cpuReadRequest),
		.buttons(buttons),
		.cpuReadData(cpuReadData),
		.interruptPending(interruptPending),
		.errorCount(errorCount),
		.readCount(readCount)
	);

	////////////////////////////////////////
	// Bus helpers
	////////////////////////////////////////

	function automatic int randomBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [15:0] unmappedAddr();
		case (randomBelow(3))
			0: return 16'(randomBelow(32'hC000));
			1: return 16'(32'hE000 + randomBelow(32'h1F00));
			default: return 16'(32'hFF10 + randomBelow(32'h70));
		endcase
	endfunction

	function automatic logic [15:0] workRamAddr();
		return 16'(gbPackage::WorkRamBase + randomBelow(int'(gbPackage::WorkRamSpan)));
	endfunction

	function automatic logic [15:0] highRamAddr();
		return 16'(gbPackage::HighRamBase + randomBelow(127));
	endfunction

	// Leaves the caller 1 ns after the next rising edge
	task automatic stepCycle();
		@(posedge clock);
		#1;
	endtask

	task automatic idleCycles(input int count);
		repeat (count) stepCycle();
	endtask

	task automatic busWrite(input logic [15:0] addr, input logic [7:0] data);
		cpuAddr = addr;
		cpuWriteData = data;
		cpuWe = 1'b1;
		stepCycle();
		cpuWe = 1'b0;
	endtask

	task automatic busRead(input logic [15:0] addr);
		cpuAddr = addr;
		cpuReadRequest = 1'b1;
		stepCycle();
		cpuReadRequest = 1'b0;
	endtask

	task automatic waitForPending(input int bitIndex, input int limit);
		int waited;
		waited = 0;
		while (!interruptPending[bitIndex] && waited < limit) begin
			stepCycle();
			waited++;
		end
		if (!interruptPending[bitIndex]) begin
			waitFailures++;
			$display("Interrupt %0d did not become pending within %0d cycles", bitIndex, limit);
		end
	endtask

	////////////////////////////////////////
	// Test phases
	////////////////////////////////////////

	task automatic ramAccesses();
		int mirrors;
		mirrors = int'(gbPackage::WorkRamSpan) / WorkRamBytes;
		// Fill every byte once, work RAM through a random mirror
		for (int i = 0; i < WorkRamBytes; i++)
			busWrite(16'(gbPackage::WorkRamBase + i + randomBelow(mirrors) * WorkRamBytes),
				8'(randomBelow(256)));
		for (int i = 0; i < 127; i++)
			busWrite(16'(gbPackage::HighRamBase + i), 8'(randomBelow(256)));
		for (int i = 0; i < 300; i++) begin
			case (randomBelow(5))
				0: busWrite(workRamAddr(), 8'(randomBelow(256)));
				1: busRead(workRamAddr());
				2: busWrite(highRamAddr(), 8'(randomBelow(256)));
				3: busRead(highRamAddr());
				default: busRead(unmappedAddr());
			endcase
		end
	endtask

	task automatic timerCounting();
		logic [7:0] control;
		busWrite(gbPackage::TacAddr, 8'h00);
		busWrite(gbPackage::DivAddr, 8'(randomBelow(256)));
		for (int i = 0; i < 8; i++) begin
			idleCycles(randomBelow(400));
			busRead(gbPackage::DivAddr);
			if (randomBelow(3) == 0)
				busWrite(gbPackage::DivAddr, 8'h00);
		end
		// Four enabled rates, then a setting with the enable bit clear
		for (int rate = 0; rate < 5; rate++) begin
			control = (rate < 4) ? 8'(4 + rate) : 8'(randomBelow(256) & 8'hFB);
			busWrite(gbPackage::TmaAddr, 8'h00);
			busWrite(gbPackage::TimaAddr, 8'h00);
			busWrite(gbPackage::TacAddr, control);
			for (int i = 0; i < 12; i++) begin
				// Rate 0 steps once per 1024 cycles, so its reads are spread wider
				idleCycles((rate == 0) ? 100 + randomBelow(150) : randomBelow(150));
				busRead(gbPackage::TimaAddr);
			end
		end
		busWrite(gbPackage::TacAddr, 8'h00);
	endtask

	task automatic overflowInterrupt();
		busWrite(gbPackage::IeAddr, 8'(1 << gbPackage::IntTimer));
		for (int round = 0; round < 3; round++) begin
			busWrite(gbPackage::IfAddr, 8'h00);
			busWrite(gbPackage::TmaAddr, 8'(randomBelow(256)));
			busWrite(gbPackage::TimaAddr, 8'hF0);
			busWrite(gbPackage::TacAddr, 8'h05);
			waitForPending(gbPackage::IntTimer, 600);
			busRead(gbPackage::TimaAddr);
			busRead(gbPackage::IfAddr);
			// Masked for a while, then enabled again
			busWrite(gbPackage::IeAddr, 8'h00);
			idleCycles(4);
			busWrite(gbPackage::IeAddr, 8'(1 << gbPackage::IntTimer));
			busWrite(gbPackage::TacAddr, 8'h00);
			busWrite(gbPackage::IfAddr, 8'h00);
			busRead(gbPackage::IfAddr);
		end
		busWrite(gbPackage::IeAddr, 8'h00);
	endtask

	task automatic joypadReads();
		for (int i = 0; i < 150; i++) begin
			buttons = 8'(randomBelow(256));
			if (randomBelow(2) == 0)
				busWrite(gbPackage::JoypadAddr, 8'(randomBelow(256)));
			idleCycles(randomBelow(4));
			busRead(gbPackage::JoypadAddr);
		end
	endtask

	task automatic interruptMasking();
		for (int i = 0; i < 60; i++) begin
			buttons = 8'h00;
			busWrite(gbPackage::JoypadAddr, 8'(randomBelow(4) << 4));
			busWrite(gbPackage::IeAddr, 8'(randomBelow(256)));
			idleCycles(3);
			busWrite(gbPackage::IfAddr, 8'h00);
			buttons = 8'(randomBelow(256));
			idleCycles(4);
			busRead(gbPackage::IfAddr);
		end
	endtask

	////////////////////////////////////////
	// Sequence and run limit
	////////////////////////////////////////

	initial begin
		seed = 30687;
		waitFailures = 0;
		phase = 3'd0;
		cpuAddr = 16'h0000;
		cpuWriteData = 8'h00;
		cpuWe = 1'b0;
		cpuReadRequest = 1'b0;
		buttons = 8'h00;
		@(negedge reset);
		phase = 3'd1;
		ramAccesses();
		phase = 3'd2;
		timerCounting();
		phase = 3'd3;
		overflowInterrupt();
		phase = 3'd4;
		joypadReads();
		phase = 3'd5;
		interruptMasking();
		idleCycles(4);
		$display("Checked %0d reads: %0d mismatches, %0d wait failures",
			readCount, errorCount, waitFailures);
		if (errorCount == 0 && waitFailures == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("Timeout: the run went past its limit of %0d cycles", CycleLimit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

endmodule

/* sources.f */
source/gbPackage.sv
source/memoryUnit.sv
source/interruptController.sv
source/timerUnit.sv
source/buttonPort.sv
source/gbCore.sv
tests/clockGen.sv
tests/gbCoreChecker.sv
tests/gbCoreTb.sv

/* run.sh */
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module gbCoreTb -o gbCoreSim -f sources.f; then
	echo "Verilator compile failed"
	exit 1
fi

simOutput=$(./obj_dir/gbCoreSim)
simStatus=$?
printf '%s\n' "$simOutput"

if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "PASS: all tests"; then
	exit 0
fi

echo "Pass line not found in simulation output"
exit 1
